/* src/isol_pkg.sv */
package isol_pkg;

  // Bus widths of every link in the subsystem
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;

  // Most transactions open at once through the demux and through the gate
  localparam int MAX_PENDING = 8;

  // Pointer width of the demux order FIFO
  localparam int PTR_W = $clog2(MAX_PENDING);
  // Counter width, one bit more so a full count fits
  localparam int CNT_W = PTR_W + 1;
  // Count value at which new requests stall
  localparam logic [CNT_W-1:0] PEND_FULL = CNT_W'(MAX_PENDING);

  // Read data returned while isolated, hexspeak for isolated
  localparam logic [DATA_W-1:0] ISOLATED_DATA = 32'h1501A7ED;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Gate FSM states
  typedef enum logic [1:0] {
    GATE_PASS     = 2'd0,
    GATE_DRAIN    = 2'd1,
    GATE_ISOLATED = 2'd2
  } gate_state_e;

endpackage

/* src/isol_demux.sv */
`timescale 1ns/1ps

module isol_demux (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Slave link from the outside manager
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  input  isol_pkg::op_e                slv_req_op_i,
  input  logic [isol_pkg::ADDR_W-1:0]  slv_req_addr_i,
  input  logic [isol_pkg::DATA_W-1:0]  slv_req_wdata_i,
  input  logic [isol_pkg::ID_W-1:0]    slv_req_id_i,
  output logic                         slv_rsp_valid_o,
  input  logic                         slv_rsp_ready_i,
  output logic [isol_pkg::DATA_W-1:0]  slv_rsp_rdata_o,
  output logic                         slv_rsp_err_o,
  output logic [isol_pkg::ID_W-1:0]    slv_rsp_id_o,
  // High routes new requests to the error responder
  input  logic                         sel_isolated_i,
  // Port 0, towards the gate
  output logic                         m0_req_valid_o,
  input  logic                         m0_req_ready_i,
  output isol_pkg::op_e                m0_req_op_o,
  output logic [isol_pkg::ADDR_W-1:0]  m0_req_addr_o,
  output logic [isol_pkg::DATA_W-1:0]  m0_req_wdata_o,
  output logic [isol_pkg::ID_W-1:0]    m0_req_id_o,
  input  logic                         m0_rsp_valid_i,
  output logic                         m0_rsp_ready_o,
  input  logic [isol_pkg::DATA_W-1:0]  m0_rsp_rdata_i,
  input  logic                         m0_rsp_err_i,
  input  logic [isol_pkg::ID_W-1:0]    m0_rsp_id_i,
  // Port 1, towards the error responder
  output logic                         m1_req_valid_o,
  input  logic                         m1_req_ready_i,
  output isol_pkg::op_e                m1_req_op_o,
  output logic [isol_pkg::ADDR_W-1:0]  m1_req_addr_o,
  output logic [isol_pkg::DATA_W-1:0]  m1_req_wdata_o,
  output logic [isol_pkg::ID_W-1:0]    m1_req_id_o,
  input  logic                         m1_rsp_valid_i,
  output logic                         m1_rsp_ready_o,
  input  logic [isol_pkg::DATA_W-1:0]  m1_rsp_rdata_i,
  input  logic                         m1_rsp_err_i,
  input  logic [isol_pkg::ID_W-1:0]    m1_rsp_id_i
);

  // Order FIFO, one bit per accepted request holding the chosen port
  logic [isol_pkg::MAX_PENDING-1:0] order_q;
  logic [isol_pkg::PTR_W-1:0]       wr_ptr_q;
  logic [isol_pkg::PTR_W-1:0]       rd_ptr_q;
  logic [isol_pkg::CNT_W-1:0]       cnt_q;
  logic                             fifo_full;
  logic                             fifo_empty;
  logic                             head;
  logic                             push;
  logic                             pop;

  assign fifo_full  = (cnt_q == isol_pkg::PEND_FULL);
  assign fifo_empty = (cnt_q == '0);
  assign head       = order_q[rd_ptr_q];

  // Payload goes to both ports, only one valid is raised
  assign m0_req_op_o    = slv_req_op_i;
  assign m0_req_addr_o  = slv_req_addr_i;
  assign m0_req_wdata_o = slv_req_wdata_i;
  assign m0_req_id_o    = slv_req_id_i;
  assign m1_req_op_o    = slv_req_op_i;
  assign m1_req_addr_o  = slv_req_addr_i;
  assign m1_req_wdata_o = slv_req_wdata_i;
  assign m1_req_id_o    = slv_req_id_i;

  // Select follows isolated_o while the request is offered
  assign m0_req_valid_o  = slv_req_valid_i && !sel_isolated_i && !fifo_full;
  assign m1_req_valid_o  = slv_req_valid_i && sel_isolated_i && !fifo_full;
  assign slv_req_ready_o = !fifo_full && (sel_isolated_i ? m1_req_ready_i : m0_req_ready_i);
  assign push            = slv_req_valid_i && slv_req_ready_o;

  // Only the port at the FIFO head may answer
  assign slv_rsp_valid_o = !fifo_empty && (head ? m1_rsp_valid_i : m0_rsp_valid_i);
  assign slv_rsp_rdata_o = head ? m1_rsp_rdata_i : m0_rsp_rdata_i;
  assign slv_rsp_err_o   = head ? m1_rsp_err_i : m0_rsp_err_i;
  assign slv_rsp_id_o    = head ? m1_rsp_id_i : m0_rsp_id_i;
  assign m0_rsp_ready_o  = !fifo_empty && !head && slv_rsp_ready_i;
  assign m1_rsp_ready_o  = !fifo_empty && head && slv_rsp_ready_i;
  assign pop             = slv_rsp_valid_o && slv_rsp_ready_i;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the level alone
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Port bits themselves, read only when not empty
  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= sel_isolated_i;
    end
  end

endmodule

/* src/isol_gate.sv */
`timescale 1ns/1ps

module isol_gate (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Slave link from the demux
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  input  isol_pkg::op_e                slv_req_op_i,
  input  logic [isol_pkg::ADDR_W-1:0]  slv_req_addr_i,
  input  logic [isol_pkg::DATA_W-1:0]  slv_req_wdata_i,
  input  logic [isol_pkg::ID_W-1:0]    slv_req_id_i,
  output logic                         slv_rsp_valid_o,
  input  logic                         slv_rsp_ready_i,
  output logic [isol_pkg::DATA_W-1:0]  slv_rsp_rdata_o,
  output logic                         slv_rsp_err_o,
  output logic [isol_pkg::ID_W-1:0]    slv_rsp_id_o,
  // Manager link towards the target
  output logic                         mst_req_valid_o,
  input  logic                         mst_req_ready_i,
  output isol_pkg::op_e                mst_req_op_o,
  output logic [isol_pkg::ADDR_W-1:0]  mst_req_addr_o,
  output logic [isol_pkg::DATA_W-1:0]  mst_req_wdata_o,
  output logic [isol_pkg::ID_W-1:0]    mst_req_id_o,
  input  logic                         mst_rsp_valid_i,
  output logic                         mst_rsp_ready_o,
  input  logic [isol_pkg::DATA_W-1:0]  mst_rsp_rdata_i,
  input  logic                         mst_rsp_err_i,
  input  logic [isol_pkg::ID_W-1:0]    mst_rsp_id_i,
  // Isolation control
  input  logic                         isolate_i,
  output logic                         isolated_o
);

  isol_pkg::gate_state_e      state_q;
  isol_pkg::gate_state_e      state_d;
  logic [isol_pkg::CNT_W-1:0] pend_q;
  logic                       pass;
  logic                       pend_full;
  logic                       req_xfer;
  logic                       rsp_xfer;

  assign pass       = (state_q == isol_pkg::GATE_PASS);
  assign isolated_o = (state_q == isol_pkg::GATE_ISOLATED);
  assign pend_full  = (pend_q == isol_pkg::PEND_FULL);

  // Requests flow only in pass state and below the pending limit
  assign mst_req_valid_o = slv_req_valid_i && pass && !pend_full;
  assign slv_req_ready_o = mst_req_ready_i && pass && !pend_full;

  // Target side request payload is zeroed while isolated
  assign mst_req_op_o    = isolated_o ? isol_pkg::OP_READ : slv_req_op_i;
  assign mst_req_addr_o  = isolated_o ? '0 : slv_req_addr_i;
  assign mst_req_wdata_o = isolated_o ? '0 : slv_req_wdata_i;
  assign mst_req_id_o    = isolated_o ? '0 : slv_req_id_i;

  // Responses pass straight back, open ones still drain
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign slv_rsp_rdata_o = mst_rsp_rdata_i;
  assign slv_rsp_err_o   = mst_rsp_err_i;
  assign slv_rsp_id_o    = mst_rsp_id_i;

  assign req_xfer = mst_req_valid_o && mst_req_ready_i;
  assign rsp_xfer = mst_rsp_valid_i && mst_rsp_ready_o;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      isol_pkg::GATE_PASS: begin
        if (isolate_i) begin
          state_d = isol_pkg::GATE_DRAIN;
        end
      end
      isol_pkg::GATE_DRAIN: begin
        // Release wins over a drain that just finished
        if (!isolate_i) begin
          state_d = isol_pkg::GATE_PASS;
        end else if (pend_q == '0) begin
          state_d = isol_pkg::GATE_ISOLATED;
        end
      end
      isol_pkg::GATE_ISOLATED: begin
        if (!isolate_i) begin
          state_d = isol_pkg::GATE_PASS;
        end
      end
      default: state_d = isol_pkg::GATE_PASS;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= isol_pkg::GATE_PASS;
      pend_q  <= '0;
    end else begin
      state_q <= state_d;
      // Open transaction count, up on request and down on response
      if (req_xfer && !rsp_xfer) begin
        pend_q <= pend_q + 1'b1;
      end else if (rsp_xfer && !req_xfer) begin
        pend_q <= pend_q - 1'b1;
      end
    end
  end

endmodule

/* src/isol_err_responder.sv */
`timescale 1ns/1ps

module isol_err_responder (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  input  isol_pkg::op_e                slv_req_op_i,
  input  logic [isol_pkg::ADDR_W-1:0]  slv_req_addr_i,
  input  logic [isol_pkg::DATA_W-1:0]  slv_req_wdata_i,
  input  logic [isol_pkg::ID_W-1:0]    slv_req_id_i,
  output logic                         slv_rsp_valid_o,
  input  logic                         slv_rsp_ready_i,
  output logic [isol_pkg::DATA_W-1:0]  slv_rsp_rdata_o,
  output logic                         slv_rsp_err_o,
  output logic [isol_pkg::ID_W-1:0]    slv_rsp_id_o
);

  // One entry response register
  logic                       rsp_valid_q;
  logic [isol_pkg::ID_W-1:0]  rsp_id_q;
  logic                       accept;

  // Opcode, address and write data never reach the target while isolated
  // every request is answered alike

  // Next request taken once the register empties or is being read
  assign slv_req_ready_o = !rsp_valid_q || slv_rsp_ready_i;
  assign accept          = slv_req_valid_i && slv_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (slv_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Only the ID is echoed
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_q <= slv_req_id_i;
    end
  end

  assign slv_rsp_valid_o = rsp_valid_q;
  assign slv_rsp_rdata_o = isol_pkg::ISOLATED_DATA;
  assign slv_rsp_err_o   = 1'b1;
  assign slv_rsp_id_o    = rsp_id_q;

endmodule

/* src/isol_mem_target.sv */
`timescale 1ns/1ps

module isol_mem_target (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         slv_req_valid_i,
  output logic                         slv_req_ready_o,
  input  isol_pkg::op_e                slv_req_op_i,
  input  logic [isol_pkg::ADDR_W-1:0]  slv_req_addr_i,
  input  logic [isol_pkg::DATA_W-1:0]  slv_req_wdata_i,
  input  logic [isol_pkg::ID_W-1:0]    slv_req_id_i,
  output logic                         slv_rsp_valid_o,
  input  logic                         slv_rsp_ready_i,
  output logic [isol_pkg::DATA_W-1:0]  slv_rsp_rdata_o,
  output logic                         slv_rsp_err_o,
  output logic [isol_pkg::ID_W-1:0]    slv_rsp_id_o
);

  // Word memory, one entry per address
  logic [isol_pkg::DATA_W-1:0] mem_q [2**isol_pkg::ADDR_W];

  logic                        rsp_valid_q;
  logic [isol_pkg::DATA_W-1:0] rsp_rdata_q;
  logic [isol_pkg::ID_W-1:0]   rsp_id_q;
  logic                        accept;

  // New request only when the response slot frees up this cycle
  assign slv_req_ready_o = !rsp_valid_q || slv_rsp_ready_i;
  assign accept          = slv_req_valid_i && slv_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (slv_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Memory access and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_q <= slv_req_id_i;
      if (slv_req_op_i == isol_pkg::OP_WRITE) begin
        mem_q[slv_req_addr_i] <= slv_req_wdata_i;
        // Writes echo their data
        rsp_rdata_q           <= slv_req_wdata_i;
      end else begin
        rsp_rdata_q <= mem_q[slv_req_addr_i];
      end
    end
  end

  assign slv_rsp_valid_o = rsp_valid_q;
  assign slv_rsp_rdata_o = rsp_rdata_q;
  assign slv_rsp_err_o   = 1'b0;
  assign slv_rsp_id_o    = rsp_id_q;

endmodule

/* src/isol_top.sv */
`timescale 1ns/1ps

module isol_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  isol_pkg::op_e                req_op_i,
  input  logic [isol_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [isol_pkg::DATA_W-1:0]  req_wdata_i,
  input  logic [isol_pkg::ID_W-1:0]    req_id_i,
  output logic                         rsp_valid_o,
  input  logic                         rsp_ready_i,
  output logic [isol_pkg::DATA_W-1:0]  rsp_rdata_o,
  output logic                         rsp_err_o,
  output logic [isol_pkg::ID_W-1:0]    rsp_id_o,
  input  logic                         isolate_i,
  output logic                         isolated_o
);

  // Demux port 0 to gate
  logic                        g_req_valid;
  logic                        g_req_ready;
  isol_pkg::op_e               g_req_op;
  logic [isol_pkg::ADDR_W-1:0] g_req_addr;
  logic [isol_pkg::DATA_W-1:0] g_req_wdata;
  logic [isol_pkg::ID_W-1:0]   g_req_id;
  logic                        g_rsp_valid;
  logic                        g_rsp_ready;
  logic [isol_pkg::DATA_W-1:0] g_rsp_rdata;
  logic                        g_rsp_err;
  logic [isol_pkg::ID_W-1:0]   g_rsp_id;

  // Demux port 1 to error responder
  logic                        e_req_valid;
  logic                        e_req_ready;
  isol_pkg::op_e               e_req_op;
  logic [isol_pkg::ADDR_W-1:0] e_req_addr;
  logic [isol_pkg::DATA_W-1:0] e_req_wdata;
  logic [isol_pkg::ID_W-1:0]   e_req_id;
  logic                        e_rsp_valid;
  logic                        e_rsp_ready;
  logic [isol_pkg::DATA_W-1:0] e_rsp_rdata;
  logic                        e_rsp_err;
  logic [isol_pkg::ID_W-1:0]   e_rsp_id;

  // Gate to memory target
  logic                        t_req_valid;
  logic                        t_req_ready;
  isol_pkg::op_e               t_req_op;
  logic [isol_pkg::ADDR_W-1:0] t_req_addr;
  logic [isol_pkg::DATA_W-1:0] t_req_wdata;
  logic [isol_pkg::ID_W-1:0]   t_req_id;
  logic                        t_rsp_valid;
  logic                        t_rsp_ready;
  logic [isol_pkg::DATA_W-1:0] t_rsp_rdata;
  logic                        t_rsp_err;
  logic [isol_pkg::ID_W-1:0]   t_rsp_id;

  // Isolation status also steers the demux
  isol_demux i_demux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_valid_i (req_valid_i),
    .slv_req_ready_o (req_ready_o),
    .slv_req_op_i    (req_op_i),
    .slv_req_addr_i  (req_addr_i),
    .slv_req_wdata_i (req_wdata_i),
    .slv_req_id_i    (req_id_i),
    .slv_rsp_valid_o (rsp_valid_o),
    .slv_rsp_ready_i (rsp_ready_i),
    .slv_rsp_rdata_o (rsp_rdata_o),
    .slv_rsp_err_o   (rsp_err_o),
    .slv_rsp_id_o    (rsp_id_o),
    .sel_isolated_i  (isolated_o),
    .m0_req_valid_o  (g_req_valid),
    .m0_req_ready_i  (g_req_ready),
    .m0_req_op_o     (g_req_op),
    .m0_req_addr_o   (g_req_addr),
    .m0_req_wdata_o  (g_req_wdata),
    .m0_req_id_o     (g_req_id),
    .m0_rsp_valid_i  (g_rsp_valid),
    .m0_rsp_ready_o  (g_rsp_ready),
    .m0_rsp_rdata_i  (g_rsp_rdata),
    .m0_rsp_err_i    (g_rsp_err),
    .m0_rsp_id_i     (g_rsp_id),
    .m1_req_valid_o  (e_req_valid),
    .m1_req_ready_i  (e_req_ready),
    .m1_req_op_o     (e_req_op),
    .m1_req_addr_o   (e_req_addr),
    .m1_req_wdata_o  (e_req_wdata),
    .m1_req_id_o     (e_req_id),
    .m1_rsp_valid_i  (e_rsp_valid),
    .m1_rsp_ready_o  (e_rsp_ready),
    .m1_rsp_rdata_i  (e_rsp_rdata),
    .m1_rsp_err_i    (e_rsp_err),
    .m1_rsp_id_i     (e_rsp_id)
  );

  isol_gate i_gate (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_valid_i (g_req_valid),
    .slv_req_ready_o (g_req_ready),
    .slv_req_op_i    (g_req_op),
    .slv_req_addr_i  (g_req_addr),
    .slv_req_wdata_i (g_req_wdata),
    .slv_req_id_i    (g_req_id),
    .slv_rsp_valid_o (g_rsp_valid),
    .slv_rsp_ready_i (g_rsp_ready),
    .slv_rsp_rdata_o (g_rsp_rdata),
    .slv_rsp_err_o   (g_rsp_err),
    .slv_rsp_id_o    (g_rsp_id),
    .mst_req_valid_o (t_req_valid),
    .mst_req_ready_i (t_req_ready),
    .mst_req_op_o    (t_req_op),
    .mst_req_addr_o  (t_req_addr),
    .mst_req_wdata_o (t_req_wdata),
    .mst_req_id_o    (t_req_id),
    .mst_rsp_valid_i (t_rsp_valid),
    .mst_rsp_ready_o (t_rsp_ready),
    .mst_rsp_rdata_i (t_rsp_rdata),
    .mst_rsp_err_i   (t_rsp_err),
    .mst_rsp_id_i    (t_rsp_id),
    .isolate_i       (isolate_i),
    .isolated_o      (isolated_o)
  );

  isol_err_responder i_err (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_valid_i (e_req_valid),
    .slv_req_ready_o (e_req_ready),
    .slv_req_op_i    (e_req_op),
    .slv_req_addr_i  (e_req_addr),
    .slv_req_wdata_i (e_req_wdata),
    .slv_req_id_i    (e_req_id),
    .slv_rsp_valid_o (e_rsp_valid),
    .slv_rsp_ready_i (e_rsp_ready),
    .slv_rsp_rdata_o (e_rsp_rdata),
    .slv_rsp_err_o   (e_rsp_err),
    .slv_rsp_id_o    (e_rsp_id)
  );

  isol_mem_target i_mem (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_req_valid_i (t_req_valid),
    .slv_req_ready_o (t_req_ready),
    .slv_req_op_i    (t_req_op),
    .slv_req_addr_i  (t_req_addr),
    .slv_req_wdata_i (t_req_wdata),
    .slv_req_id_i    (t_req_id),
    .slv_rsp_valid_o (t_rsp_valid),
    .slv_rsp_ready_i (t_rsp_ready),
    .slv_rsp_rdata_o (t_rsp_rdata),
    .slv_rsp_err_o   (t_rsp_err),
    .slv_rsp_id_o    (t_rsp_id)
  );

endmodule

/* tb/isol_properties.sv */
`timescale 1ns/1ps

module isol_properties (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        req_valid_i,
  input logic                        req_ready_i,
  input logic                        rsp_valid_i,
  input logic                        rsp_ready_i,
  input logic [isol_pkg::DATA_W-1:0] rsp_rdata_i,
  input logic                        rsp_err_i,
  input logic [isol_pkg::ID_W-1:0]   rsp_id_i,
  input logic                        isolate_i,
  input logic                        isolated_i
);

  // Responses still owed to the manager at the top level
  logic [isol_pkg::CNT_W-1:0] open_q;
  // Set by the first accepted request after reset
  logic                       any_req_q;
  logic                       req_xfer;
  logic                       rsp_xfer;

  assign req_xfer = req_valid_i && req_ready_i;
  assign rsp_xfer = rsp_valid_i && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q <= '0;
    end else if (req_xfer && !rsp_xfer) begin
      open_q <= open_q + 1'b1;
    end else if (rsp_xfer && !req_xfer) begin
      open_q <= open_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      any_req_q <= 1'b0;
    end else if (req_xfer) begin
      any_req_q <= 1'b1;
    end
  end

  // Held response keeps valid and payload until taken
  rsp_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) &&
    $stable(rsp_err_i) && $stable(rsp_id_i))
    else $error("response changed while held under back-pressure");

  // Out of reset nothing is answered or isolated before the first request
  quiet_until_first_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !any_req_q |-> !rsp_valid_i && !isolated_i)
    else $error("rsp_valid_o or isolated_o high before the first request");

  // Isolation only follows a request for it
  isolated_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated_i |-> $past(isolate_i))
    else $error("isolated_o high without isolate_i in the cycle before");

  // Drain must be complete when isolation is reported
  isolated_after_drain: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(isolated_i) |-> (open_q == '0))
    else $error("isolated_o rose while responses were outstanding");

endmodule

bind isol_top isol_properties u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_rdata_i (rsp_rdata_o),
  .rsp_err_i   (rsp_err_o),
  .rsp_id_i    (rsp_id_o),
  .isolate_i   (isolate_i),
  .isolated_i  (isolated_o)
);

/* tb/isol_tb.sv */
`timescale 1ns/1ps

module isol_tb;

  localparam int TIMEOUT = 200;
  // Expected response packed as id, error flag, data
  localparam int EXP_W = isol_pkg::ID_W + 1 + isol_pkg::DATA_W;

  logic                        clk_i = 1'b0;
  logic                        rst_n_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  isol_pkg::op_e               req_op_i;
  logic [isol_pkg::ADDR_W-1:0] req_addr_i;
  logic [isol_pkg::DATA_W-1:0] req_wdata_i;
  logic [isol_pkg::ID_W-1:0]   req_id_i;
  logic                        rsp_valid_o;
  logic                        rsp_ready_i;
  logic [isol_pkg::DATA_W-1:0] rsp_rdata_o;
  logic                        rsp_err_o;
  logic [isol_pkg::ID_W-1:0]   rsp_id_o;
  logic                        isolate_i;
  logic                        isolated_o;

  // Reference model state
  logic [isol_pkg::DATA_W-1:0] ref_mem [2**isol_pkg::ADDR_W];
  logic [EXP_W-1:0]            exp_q [$];
  logic [isol_pkg::ADDR_W-1:0] written_q [$];
  logic [isol_pkg::ID_W-1:0]   next_id;
  logic [isol_pkg::ADDR_W-1:0] kept_addr;
  logic [isol_pkg::ADDR_W-1:0] addr;
  int                          ready_pct;
  int                          errors;
  int                          n_req;
  int                          n_rsp;

  isol_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_id_i    (req_id_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_id_o    (rsp_id_o),
    .isolate_i   (isolate_i),
    .isolated_o  (isolated_o)
  );

  always #10 clk_i = ~clk_i;

  // Random response back-pressure, ready_pct percent of cycles ready
  always @(posedge clk_i) begin
    rsp_ready_i <= (($urandom % 100) < ready_pct);
  end

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // Requests push expectations, responses are compared in order
  always @(posedge clk_i) begin : monitor
    logic [EXP_W-1:0] exp;
    if (rst_n_i) begin
      if (req_valid_i && req_ready_o) begin
        n_req++;
        if (isolated_o) begin
          exp_q.push_back({req_id_i, 1'b1, isol_pkg::ISOLATED_DATA});
        end else if (req_op_i == isol_pkg::OP_WRITE) begin
          ref_mem[req_addr_i] = req_wdata_i;
          exp_q.push_back({req_id_i, 1'b0, req_wdata_i});
        end else begin
          exp_q.push_back({req_id_i, 1'b0, ref_mem[req_addr_i]});
        end
      end
      if (rsp_valid_o && rsp_ready_i) begin
        n_rsp++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response at %0t arrived with no request outstanding", $time);
        end else begin
          exp = exp_q.pop_front();
          check_field("rsp_id_o", 32'(exp[EXP_W-1 -: isol_pkg::ID_W]), 32'(rsp_id_o));
          check_field("rsp_err_o", 32'(exp[isol_pkg::DATA_W]), 32'(rsp_err_o));
          check_field("rsp_rdata_o", exp[isol_pkg::DATA_W-1:0], rsp_rdata_o);
        end
      end
    end
  end

  task automatic start_req(input isol_pkg::op_e op, input logic [isol_pkg::ADDR_W-1:0] a,
                           input logic [isol_pkg::DATA_W-1:0] data);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_addr_i  <= a;
    req_wdata_i <= data;
    req_id_i    <= next_id;
    next_id     = next_id + 4'd1;
  endtask

  // Valid stays up until the edge where ready is seen
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (!req_ready_o && cycles < TIMEOUT) begin
      cycles++;
      @(posedge clk_i);
    end
    if (!req_ready_o) begin
      errors++;
      $display("Timeout at %0t: request was never accepted", $time);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic send_req(input isol_pkg::op_e op, input logic [isol_pkg::ADDR_W-1:0] a,
                          input logic [isol_pkg::DATA_W-1:0] data);
    start_req(op, a, data);
    wait_accept();
  endtask

  // First edge lets the monitor record the request accepted just before
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
      cycles++;
      @(posedge clk_i);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
    end
  endtask

  task automatic wait_isolated(input logic level);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (isolated_o !== level && cycles < TIMEOUT) begin
      cycles++;
      @(posedge clk_i);
    end
    if (isolated_o !== level) begin
      errors++;
      $display("Timeout at %0t: isolated_o never reached %0b", $time, level);
    end
  endtask

  // Outputs that must stay low over a stretch of cycles
  task automatic check_quiet(input int cycles, input logic check_rsp);
    repeat (cycles) begin
      @(posedge clk_i);
      if (check_rsp) begin
        check_field("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
      end
      check_field("isolated_o", 32'd0, 32'(isolated_o));
    end
  endtask

  function automatic logic [isol_pkg::ADDR_W-1:0] pick_written();
    return written_q[$urandom % written_q.size()];
  endfunction

  initial begin
    void'($urandom(32'h2b20));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = isol_pkg::OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_id_i    = '0;
    rsp_ready_i = 1'b0;
    isolate_i   = 1'b0;
    ready_pct   = 100;
    next_id     = '0;
    errors      = 0;
    n_req       = 0;
    n_rsp       = 0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Quiet after reset
    check_quiet(4, 1'b1);
    // Pass-through writes then reads with random gaps
    ready_pct <= 60;
    repeat (12) begin
      addr = isol_pkg::ADDR_W'($urandom);
      written_q.push_back(addr);
      send_req(isol_pkg::OP_WRITE, addr, $urandom);
    end
    repeat (12) send_req(isol_pkg::OP_READ, pick_written(), '0);
    wait_drain();
    // Isolate with one transaction held open
    kept_addr = written_q[0];
    ready_pct <= 0;
    send_req(isol_pkg::OP_READ, kept_addr, '0);
    isolate_i <= 1'b1;
    check_quiet(6, 1'b0);
    ready_pct <= 70;
    wait_isolated(1'b1);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("Isolation reported at %0t with responses still open", $time);
    end
    // Error responses, the write must not reach memory
    send_req(isol_pkg::OP_WRITE, kept_addr, ~ref_mem[kept_addr]);
    repeat (6) begin
      send_req((($urandom & 1) != 0) ? isol_pkg::OP_WRITE : isol_pkg::OP_READ,
               isol_pkg::ADDR_W'($urandom), $urandom);
    end
    wait_drain();
    // Release and check memory kept its value
    isolate_i <= 1'b0;
    wait_isolated(1'b0);
    send_req(isol_pkg::OP_READ, kept_addr, '0);
    repeat (10) begin
      if (($urandom & 1) != 0) begin
        addr = isol_pkg::ADDR_W'($urandom);
        written_q.push_back(addr);
        send_req(isol_pkg::OP_WRITE, addr, $urandom);
      end else begin
        send_req(isol_pkg::OP_READ, pick_written(), '0);
      end
    end
    wait_drain();
    // Long stall with a held response and a waiting request
    ready_pct <= 0;
    send_req(isol_pkg::OP_WRITE, kept_addr, $urandom);
    start_req(isol_pkg::OP_READ, kept_addr, '0);
    repeat (30) @(posedge clk_i);
    ready_pct <= 100;
    wait_accept();
    wait_drain();
    // No duplicated response after the last one
    check_quiet(4, 1'b1);
    assert (n_req == n_rsp) else begin
      errors++;
      $display("Request and response counts differ");
    end
    $display("Requests %0d, responses %0d, errors %0d", n_req, n_rsp, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* isol.f */
src/isol_pkg.sv
src/isol_demux.sv
src/isol_gate.sv
src/isol_err_responder.sv
src/isol_mem_target.sv
src/isol_top.sv
tb/isol_properties.sv
tb/isol_tb.sv

/* Makefile */
TOP := isol_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): isol.f $(wildcard src/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f isol.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f isol.f

clean:
	rm -rf obj_dir
